// File: src/usiBusPkg.sv
package usiBusPkg;

  // ----------------------------------------
  // Bus geometry
  // ----------------------------------------
  // Data and address width of the host bus
  localparam int usiBusWidth = 32;
  // Block select field, sits above the CSR offset field
  localparam int blockAdrsWidth = 3;
  // CSR offset field common to every block
  localparam int csrAdrsWidth = 16;
  // Offset bits actually decoded by the slaves
  localparam int csrActiveWidth = 8;

  // Block address map
  localparam logic [blockAdrsWidth-1:0] gpioAdrsMap = 3'd0;
  localparam logic [blockAdrsWidth-1:0] sysTimerAdrsMap = 3'd4;

  // Host command, one per cycle
  typedef enum logic [1:0] {
    usiIdle  = 2'b00,
    usiWrite = 2'b01,
    usiRead  = 2'b10
  } usiOpE;

endpackage

// File: src/blockCsrPkg.sv
package blockCsrPkg;

  // ----------------------------------------
  // GPIO block CSR map
  // ----------------------------------------
  // Output data
  localparam logic [usiBusPkg::csrActiveWidth-1:0] gpioOutOfs = 8'h00;
  // Direction, 1 drives the pad
  localparam logic [usiBusPkg::csrActiveWidth-1:0] gpioDirOfs = 8'h04;
  // Alternate function select
  localparam logic [usiBusPkg::csrActiveWidth-1:0] gpioAltOfs = 8'h08;
  // Synchronized pad input, read only
  localparam logic [usiBusPkg::csrActiveWidth-1:0] gpioInOfs = 8'h0C;

  // ----------------------------------------
  // System timer CSR map
  // ----------------------------------------
  localparam logic [usiBusPkg::csrActiveWidth-1:0] timerCtrlOfs = 8'h00;
  localparam logic [usiBusPkg::csrActiveWidth-1:0] timerReloadOfs = 8'h04;
  // Live count, read only
  localparam logic [usiBusPkg::csrActiveWidth-1:0] timerCountOfs = 8'h08;
  // Sticky expiry, write 1 to clear
  localparam logic [usiBusPkg::csrActiveWidth-1:0] timerStatusOfs = 8'h0C;

  // Bit positions inside ctrl and status
  localparam int timerEnBit = 0;
  localparam int timerExpiredBit = 0;

  // Alternate source per GPIO pin, value is the pin index
  typedef enum logic [1:0] {
    altHeartbeat = 2'd0,
    altTimerTick = 2'd1,
    altTimerFlag = 2'd2
  } gpioAltSelE;

endpackage

// File: src/gpioPin.sv
`timescale 1ns/1ps

module gpioPin
(
  input  logic iSCLK,
  input  logic qnARST,
  // From the control registers
  input  logic pinOut,
  input  logic pinDir,
  input  logic pinAlt,
  // Alternate function source
  input  logic altSrc,
  // Pad side
  input  logic padIn,
  output logic padOut,
  output logic padOe,
  // Synchronized input back to the CSR block
  output logic pinIn
);

  // First synchronizer stage
  logic syncMeta;

  // Alternate source wins over the register bit
  assign padOut = pinAlt ? altSrc : pinOut;
  // 1 drives the pad, 0 leaves it as input
  assign padOe = pinDir;

  // Two flop synchronizer, pad is asynchronous to iSCLK
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      syncMeta <= 1'b0;
      pinIn    <= 1'b0;
    end
    else
    begin
      syncMeta <= padIn;
      pinIn    <= syncMeta;
    end
  end

endmodule

// File: src/gpioCsr.sv
`timescale 1ns/1ps

module gpioCsr #(
  parameter int gpioWidth = 3
)
(
  input  logic                                  iSCLK,
  input  logic                                  qnARST,
  // Slave bus side
  input  logic                                  gpioWrEn,
  input  logic                                  gpioRdEn,
  input  logic [usiBusPkg::csrActiveWidth-1:0]  sUsiOfs,
  input  logic [usiBusPkg::usiBusWidth-1:0]     sUsiWd,
  output logic [usiBusPkg::usiBusWidth-1:0]     gpioRd,
  // Alternate sources, one per pin
  input  logic [gpioWidth-1:0]                  altSrc,
  // Pads
  output logic [gpioWidth-1:0]                  gpioOut,
  output logic [gpioWidth-1:0]                  gpioOe,
  input  logic [gpioWidth-1:0]                  gpioIn
);

  // Control registers
  logic [gpioWidth-1:0]                outReg;
  logic [gpioWidth-1:0]                dirReg;
  logic [gpioWidth-1:0]                altReg;
  // Synchronized pad inputs from the pin cells
  logic [gpioWidth-1:0]                pinIn;
  logic [usiBusPkg::usiBusWidth-1:0]   rdWord;

  // ----------------------------------------
  // CSR write
  // ----------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      outReg <= '0;
      dirReg <= '0;
      altReg <= '0;
    end
    else if (gpioWrEn)
    begin
      // Input offset is read only, other offsets ignored
      case (sUsiOfs)
        blockCsrPkg::gpioOutOfs: outReg <= sUsiWd[gpioWidth-1:0];
        blockCsrPkg::gpioDirOfs: dirReg <= sUsiWd[gpioWidth-1:0];
        blockCsrPkg::gpioAltOfs: altReg <= sUsiWd[gpioWidth-1:0];
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // CSR read
  // ----------------------------------------
  always_comb
  begin
    rdWord = '0;
    case (sUsiOfs)
      blockCsrPkg::gpioOutOfs: rdWord[gpioWidth-1:0] = outReg;
      blockCsrPkg::gpioDirOfs: rdWord[gpioWidth-1:0] = dirReg;
      blockCsrPkg::gpioAltOfs: rdWord[gpioWidth-1:0] = altReg;
      blockCsrPkg::gpioInOfs:  rdWord[gpioWidth-1:0] = pinIn;
      default:                 rdWord = '0;
    endcase
  end

  // Held until the next read of this block
  always_ff @(posedge iSCLK)
  begin
    if (gpioRdEn)
      gpioRd <= rdWord;
  end

  // ----------------------------------------
  // Pin cells
  // ----------------------------------------
  for (genvar i = 0; i < gpioWidth; i++)
  begin : gPin
    gpioPin uPin (
      .iSCLK  (iSCLK),
      .qnARST (qnARST),
      .pinOut (outReg[i]),
      .pinDir (dirReg[i]),
      .pinAlt (altReg[i]),
      .altSrc (altSrc[i]),
      .padIn  (gpioIn[i]),
      .padOut (gpioOut[i]),
      .padOe  (gpioOe[i]),
      .pinIn  (pinIn[i])
    );
  end

endmodule

// File: src/sysTimer.sv
`timescale 1ns/1ps

module sysTimer #(
  parameter int timerWidth = 32
)
(
  input  logic                                  iSCLK,
  input  logic                                  qnARST,
  // Slave bus side
  input  logic                                  timerWrEn,
  input  logic                                  timerRdEn,
  input  logic [usiBusPkg::csrActiveWidth-1:0]  sUsiOfs,
  input  logic [usiBusPkg::usiBusWidth-1:0]     sUsiWd,
  output logic [usiBusPkg::usiBusWidth-1:0]     timerRd,
  // Expiry outputs
  output logic                                  timerTick,
  output logic                                  timerFlag
);

  logic                               enReg;
  logic [timerWidth-1:0]              reloadReg;
  logic [timerWidth-1:0]              count;
  // Write strobes per CSR
  logic                               ctrlWr;
  logic                               reloadWr;
  logic                               statusClr;
  logic [usiBusPkg::usiBusWidth-1:0]  rdWord;

  assign ctrlWr    = timerWrEn && (sUsiOfs == blockCsrPkg::timerCtrlOfs);
  assign reloadWr  = timerWrEn && (sUsiOfs == blockCsrPkg::timerReloadOfs);
  assign statusClr = timerWrEn && (sUsiOfs == blockCsrPkg::timerStatusOfs)
                     && sUsiWd[blockCsrPkg::timerExpiredBit];

  // Pulse in the zero cycle, period is reload + 1
  assign timerTick = enReg && (count == '0);

  // ----------------------------------------
  // Control and counter
  // ----------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      enReg     <= 1'b0;
      reloadReg <= '0;
      count     <= '0;
      timerFlag <= 1'b0;
    end
    else
    begin
      if (ctrlWr)
        enReg <= sUsiWd[blockCsrPkg::timerEnBit];
      if (reloadWr)
        reloadReg <= sUsiWd[timerWidth-1:0];
      // Count holds while disabled
      if (timerTick)
        count <= reloadReg;
      else if (enReg)
        count <= count - 1'b1;
      // New expiry beats a clear in the same cycle
      if (timerTick)
        timerFlag <= 1'b1;
      else if (statusClr)
        timerFlag <= 1'b0;
    end
  end

  // ----------------------------------------
  // CSR read
  // ----------------------------------------
  always_comb
  begin
    rdWord = '0;
    case (sUsiOfs)
      blockCsrPkg::timerCtrlOfs:   rdWord[blockCsrPkg::timerEnBit] = enReg;
      blockCsrPkg::timerReloadOfs: rdWord[timerWidth-1:0] = reloadReg;
      blockCsrPkg::timerCountOfs:  rdWord[timerWidth-1:0] = count;
      blockCsrPkg::timerStatusOfs: rdWord[blockCsrPkg::timerExpiredBit] = timerFlag;
      default:                     rdWord = '0;
    endcase
  end

  always_ff @(posedge iSCLK)
  begin
    if (timerRdEn)
      timerRd <= rdWord;
  end

endmodule

// File: src/heartbeatLed.sv
`timescale 1ns/1ps

module heartbeatLed #(
  parameter int blinkCntMax = 24999999
)
(
  input  logic iSCLK,
  input  logic qnARST,
  output logic heartbeat
);

  // Just wide enough for blinkCntMax
  localparam int cntWidth = (blinkCntMax > 0) ? $clog2(blinkCntMax + 1) : 1;

  logic [cntWidth-1:0] cnt;
  logic                wrap;

  assign wrap = (cnt == cntWidth'(blinkCntMax));

  // ----------------------------------------
  // Wrap counter and toggle
  // ----------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      cnt       <= '0;
      heartbeat <= 1'b0;
    end
    else if (wrap)
    begin
      // toggles once per blinkCntMax + 1 cycles
      cnt       <= '0;
      heartbeat <= ~heartbeat;
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule

// File: src/usiBusFabric.sv
`timescale 1ns/1ps

module usiBusFabric
(
  input  logic                                     iSCLK,
  input  logic                                     qnARST,
  // Host side
  input  usiBusPkg::usiOpE                         usiCmd,
  input  logic [usiBusPkg::usiBusWidth-1:0]        usiAdrs,
  input  logic [usiBusPkg::usiBusWidth-1:0]        usiWd,
  output logic [usiBusPkg::usiBusWidth-1:0]        usiRd,
  output logic                                     usiRdVd,
  // Slave side, per block enables
  output logic                                     gpioWrEn,
  output logic                                     gpioRdEn,
  output logic                                     timerWrEn,
  output logic                                     timerRdEn,
  // Broadcast offset and write data
  output logic [usiBusPkg::csrActiveWidth-1:0]     sUsiOfs,
  output logic [usiBusPkg::usiBusWidth-1:0]        sUsiWd,
  // Registered slave read words
  input  logic [usiBusPkg::usiBusWidth-1:0]        gpioRd,
  input  logic [usiBusPkg::usiBusWidth-1:0]        timerRd
);

  // Command stage
  usiBusPkg::usiOpE                        cmdOp;
  logic [usiBusPkg::blockAdrsWidth-1:0]    cmdBlk;
  logic [usiBusPkg::csrActiveWidth-1:0]    cmdOfs;
  logic [usiBusPkg::usiBusWidth-1:0]       cmdWd;
  // Read tracking, aligned with slave enables then slave read word
  logic                                    rdP1;
  logic                                    rdP2;
  logic [usiBusPkg::blockAdrsWidth-1:0]    blkP1;
  logic [usiBusPkg::blockAdrsWidth-1:0]    blkP2;
  logic [usiBusPkg::usiBusWidth-1:0]       selRd;

  // ----------------------------------------
  // Host command capture
  // ----------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
      cmdOp <= usiBusPkg::usiIdle;
    else
      cmdOp <= usiCmd;
  end

  // Block field right above the 16 bit CSR field
  always_ff @(posedge iSCLK)
  begin
    cmdBlk <= usiAdrs[usiBusPkg::csrAdrsWidth +: usiBusPkg::blockAdrsWidth];
    cmdOfs <= usiAdrs[usiBusPkg::csrActiveWidth-1:0];
    cmdWd  <= usiWd;
  end

  // ----------------------------------------
  // Decode and broadcast
  // ----------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      gpioWrEn  <= 1'b0;
      gpioRdEn  <= 1'b0;
      timerWrEn <= 1'b0;
      timerRdEn <= 1'b0;
      rdP1      <= 1'b0;
      rdP2      <= 1'b0;
      blkP1     <= '0;
      blkP2     <= '0;
    end
    else
    begin
      // Unmapped blocks get no enable at all
      gpioWrEn  <= (cmdOp == usiBusPkg::usiWrite) && (cmdBlk == usiBusPkg::gpioAdrsMap);
      gpioRdEn  <= (cmdOp == usiBusPkg::usiRead) && (cmdBlk == usiBusPkg::gpioAdrsMap);
      timerWrEn <= (cmdOp == usiBusPkg::usiWrite) && (cmdBlk == usiBusPkg::sysTimerAdrsMap);
      timerRdEn <= (cmdOp == usiBusPkg::usiRead) && (cmdBlk == usiBusPkg::sysTimerAdrsMap);
      // Every read returns, mapped or not
      rdP1      <= (cmdOp == usiBusPkg::usiRead);
      rdP2      <= rdP1;
      blkP1     <= cmdBlk;
      blkP2     <= blkP1;
    end
  end

  always_ff @(posedge iSCLK)
  begin
    sUsiOfs <= cmdOfs;
    sUsiWd  <= cmdWd;
  end

  // ----------------------------------------
  // Read return
  // ----------------------------------------
  always_comb
  begin
    case (blkP2)
      usiBusPkg::gpioAdrsMap:     selRd = gpioRd;
      usiBusPkg::sysTimerAdrsMap: selRd = timerRd;
      // unmapped block reads as zero
      default:                    selRd = '0;
    endcase
  end

  // One cycle valid strobe, three cycles after the command
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      usiRd   <= '0;
      usiRdVd <= 1'b0;
    end
    else
    begin
      usiRdVd <= rdP2;
      if (rdP2)
        usiRd <= selRd;
    end
  end

endmodule

// File: src/usiPeripheralTop.sv
`timescale 1ns/1ps

module usiPeripheralTop #(
  parameter int gpioWidth = 3,
  parameter int blinkCntMax = 24999999,
  parameter int timerWidth = 32
)
(
  input  logic                                iSCLK,
  input  logic                                qnARST,
  // Host bus
  input  usiBusPkg::usiOpE                    usiCmd,
  input  logic [usiBusPkg::usiBusWidth-1:0]   usiAdrs,
  input  logic [usiBusPkg::usiBusWidth-1:0]   usiWd,
  output logic [usiBusPkg::usiBusWidth-1:0]   usiRd,
  output logic                                usiRdVd,
  // GPIO pads
  input  logic [gpioWidth-1:0]                gpioIn,
  output logic [gpioWidth-1:0]                gpioOut,
  output logic [gpioWidth-1:0]                gpioOe
);

  // Slave bus
  logic                                 gpioWrEn;
  logic                                 gpioRdEn;
  logic                                 timerWrEn;
  logic                                 timerRdEn;
  logic [usiBusPkg::csrActiveWidth-1:0] sUsiOfs;
  logic [usiBusPkg::usiBusWidth-1:0]    sUsiWd;
  logic [usiBusPkg::usiBusWidth-1:0]    gpioRd;
  logic [usiBusPkg::usiBusWidth-1:0]    timerRd;
  // Alternate function sources
  logic                                 timerTick;
  logic                                 timerFlag;
  logic                                 heartbeat;
  logic [gpioWidth-1:0]                 altSrc;

  // ----------------------------------------
  // Alternate source per pin
  // ----------------------------------------
  always_comb
  begin
    altSrc = '0;
    altSrc[blockCsrPkg::altHeartbeat] = heartbeat;
    altSrc[blockCsrPkg::altTimerTick] = timerTick;
    altSrc[blockCsrPkg::altTimerFlag] = timerFlag;
  end

  usiBusFabric uFabric (
    .iSCLK(iSCLK), .qnARST(qnARST),
    .usiCmd(usiCmd), .usiAdrs(usiAdrs), .usiWd(usiWd),
    .usiRd(usiRd), .usiRdVd(usiRdVd),
    .gpioWrEn(gpioWrEn), .gpioRdEn(gpioRdEn),
    .timerWrEn(timerWrEn), .timerRdEn(timerRdEn),
    .sUsiOfs(sUsiOfs), .sUsiWd(sUsiWd),
    .gpioRd(gpioRd), .timerRd(timerRd)
  );

  gpioCsr #(.gpioWidth(gpioWidth)) uGpio (
    .iSCLK(iSCLK), .qnARST(qnARST),
    .gpioWrEn(gpioWrEn), .gpioRdEn(gpioRdEn),
    .sUsiOfs(sUsiOfs), .sUsiWd(sUsiWd), .gpioRd(gpioRd),
    .altSrc(altSrc),
    .gpioOut(gpioOut), .gpioOe(gpioOe), .gpioIn(gpioIn)
  );

  sysTimer #(.timerWidth(timerWidth)) uTimer (
    .iSCLK(iSCLK), .qnARST(qnARST),
    .timerWrEn(timerWrEn), .timerRdEn(timerRdEn),
    .sUsiOfs(sUsiOfs), .sUsiWd(sUsiWd), .timerRd(timerRd),
    .timerTick(timerTick), .timerFlag(timerFlag)
  );

  // Free running, not on the bus
  heartbeatLed #(.blinkCntMax(blinkCntMax)) uHeartbeat (
    .iSCLK(iSCLK), .qnARST(qnARST),
    .heartbeat(heartbeat)
  );

endmodule

// File: verification/usiBus_asserts.sv
`timescale 1ns/1ps

module usiBusAsserts #(
  parameter int gpioWidth = 3
)
(
  input logic                 iSCLK,
  input logic                 qnARST,
  input usiBusPkg::usiOpE     usiCmd,
  input logic                 usiRdVd,
  input logic [gpioWidth-1:0] gpioOe
);

  // ----------------------------------------
  // Read return timing
  // ----------------------------------------
  // Read sampled at edge N shows valid at edge N+4 sample
  // Samples from before the first clocks count as no read
  rdVdLatency: assert property (@(posedge iSCLK) disable iff (!qnARST)
    usiRdVd == ($past(usiCmd, 4) === usiBusPkg::usiRead))
    else $error("usiRdVd does not follow a read by exactly 3 cycles");

  // ----------------------------------------
  // Reset state
  // ----------------------------------------
  oeInReset: assert property (@(posedge iSCLK) !qnARST |-> (gpioOe == '0))
    else $error("gpioOe not zero during reset");

  rdVdInReset: assert property (@(posedge iSCLK) !qnARST |-> !usiRdVd)
    else $error("usiRdVd high during reset");

endmodule

bind usiPeripheralTop usiBusAsserts #(.gpioWidth(gpioWidth)) uBusAsserts (
  .iSCLK(iSCLK),
  .qnARST(qnARST),
  .usiCmd(usiCmd),
  .usiRdVd(usiRdVd),
  .gpioOe(gpioOe)
);

// File: verification/usiPeripheralTb.sv
`timescale 1ns/1ps

module usiPeripheralTb;

  localparam int gpioWidth = 3;
  localparam int blinkCntMax = 9;
  localparam int timerWidth = 32;
  localparam int clkPeriodNs = 40;
  // Inputs change this long after the rising edge
  localparam int drvDly = 2;
  localparam logic [31:0] gpioMask = (32'd1 << gpioWidth) - 32'd1;

  // ----------------------------------------
  // Cycle budget per test
  // ----------------------------------------
  // Bus write takes 3 cycles and bus read 4
  localparam int resetCycles = 2;
  localparam int eventLimit = 60;
  localparam int defaultsCycles = 8 * 4 + 2;
  localparam int readbackCycles = 32;
  localparam int gpioCycles = 20;
  localparam int timerCycles = 6 * 3 + 2 * 4 + eventLimit;
  localparam int heartbeatCycles = 2 * 3 + eventLimit;
  localparam int totalCycles = resetCycles + defaultsCycles + readbackCycles
                               + gpioCycles + timerCycles + heartbeatCycles;
  localparam int watchdogNs = 2 * totalCycles * clkPeriodNs;

  logic                   iSCLK;
  logic                   qnARST;
  usiBusPkg::usiOpE       usiCmd;
  logic [31:0]            usiAdrs;
  logic [31:0]            usiWd;
  logic [31:0]            usiRd;
  logic                   usiRdVd;
  logic [gpioWidth-1:0]   gpioIn;
  logic [gpioWidth-1:0]   gpioOut;
  logic [gpioWidth-1:0]   gpioOe;

  int                     errorCount;
  int                     testCount;
  int                     testErrStart;
  integer                 seed;
  // Cycle numbers of pin events seen by recordEvents
  int                     eventCycle[$];

  usiPeripheralTop #(
    .gpioWidth(gpioWidth),
    .blinkCntMax(blinkCntMax),
    .timerWidth(timerWidth)
  ) uut (
    .iSCLK(iSCLK), .qnARST(qnARST),
    .usiCmd(usiCmd), .usiAdrs(usiAdrs), .usiWd(usiWd),
    .usiRd(usiRd), .usiRdVd(usiRdVd),
    .gpioIn(gpioIn), .gpioOut(gpioOut), .gpioOe(gpioOe)
  );

  initial
  begin
    iSCLK = 1'b0;
    forever #(clkPeriodNs / 2) iSCLK = ~iSCLK;
  end

  // ----------------------------------------
  // Bus helpers
  // ----------------------------------------
  // Block in bits 18:16 and CSR offset in bits 7:0
  function automatic logic [31:0] makeAdrs(input logic [2:0] blk, input logic [7:0] ofs);
    logic [31:0] adrs;
    adrs = '0;
    adrs[18:16] = blk;
    adrs[7:0] = ofs;
    return adrs;
  endfunction

  // One command sampled at the next rising edge
  task automatic driveCmd(input usiBusPkg::usiOpE op, input logic [31:0] adrs,
                          input logic [31:0] data);
    usiCmd = op;
    usiAdrs = adrs;
    usiWd = data;
    @(posedge iSCLK);
    #drvDly;
  endtask

  // CSR is updated when this returns
  task automatic busWrite(input logic [2:0] blk, input logic [7:0] ofs, input logic [31:0] data);
    driveCmd(usiBusPkg::usiWrite, makeAdrs(blk, ofs), data);
    driveCmd(usiBusPkg::usiIdle, '0, '0);
    driveCmd(usiBusPkg::usiIdle, '0, '0);
  endtask

  task automatic busRead(input logic [2:0] blk, input logic [7:0] ofs, output logic [31:0] data);
    int waited;
    driveCmd(usiBusPkg::usiRead, makeAdrs(blk, ofs), '0);
    usiCmd = usiBusPkg::usiIdle;
    waited = 0;
    while (!usiRdVd && waited < 3)
    begin
      @(posedge iSCLK);
      #drvDly;
      waited++;
    end
    if (!usiRdVd)
    begin
      errorCount++;
      $display("Read of block %0d offset 0x%02h got no usiRdVd within 3 cycles", blk, ofs);
    end
    else if (waited != 3)
    begin
      errorCount++;
      $display("Read of block %0d offset 0x%02h returned after %0d cycles", blk, ofs, waited);
    end
    data = usiRd;
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", testName, expected, actual);
    end
  endtask

  task automatic startTest();
    testErrStart = errorCount;
  endtask

  task automatic reportTest(input string testName);
    testCount++;
    $display("%s finished with %0d errors", testName, errorCount - testErrStart);
  endtask

  // Pulse mode counts high samples and toggle mode counts value changes
  task automatic recordEvents(input string testName, input int pin, input bit toggleMode,
                              input int wanted);
    int cycle;
    logic prev;
    eventCycle.delete();
    prev = gpioOut[pin];
    cycle = 0;
    while (eventCycle.size() < wanted && cycle < eventLimit)
    begin
      @(posedge iSCLK);
      #drvDly;
      cycle++;
      if (toggleMode ? (gpioOut[pin] != prev) : gpioOut[pin])
        eventCycle.push_back(cycle);
      prev = gpioOut[pin];
    end
    if (eventCycle.size() < wanted)
    begin
      errorCount++;
      $display("%s saw only %0d of %0d events on gpioOut[%0d] in %0d cycles",
               testName, eventCycle.size(), wanted, pin, eventLimit);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic resetDefaults();
    logic [31:0] rd;
    startTest();
    checkValue("resetDefaults", 32'd0, 32'(gpioOe));
    checkValue("resetDefaults", 32'd0, 32'(usiRdVd));
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioDirOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioAltOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioInOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerCtrlOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerReloadOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerCountOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerStatusOfs, rd);
    checkValue("resetDefaults", 32'd0, rd);
    reportTest("resetDefaults");
  endtask

  task automatic csrReadback();
    logic [31:0] outVal;
    logic [31:0] reloadVal;
    logic [31:0] newVal;
    logic [31:0] rd;
    logic [31:0] expected[3];
    int i;
    startTest();
    outVal = $random(seed);
    reloadVal = $random(seed);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs, outVal);
    busWrite(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerReloadOfs, reloadVal);
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs, rd);
    checkValue("csrReadback", outVal & gpioMask, rd);
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerReloadOfs, rd);
    // Timer is 32 bits wide so nothing is masked
    checkValue("csrReadback", reloadVal, rd);
    // Three reads back to back
    expected[0] = outVal & gpioMask;
    expected[1] = reloadVal;
    expected[2] = outVal & gpioMask;
    driveCmd(usiBusPkg::usiRead, makeAdrs(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs), '0);
    driveCmd(usiBusPkg::usiRead,
             makeAdrs(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerReloadOfs), '0);
    driveCmd(usiBusPkg::usiRead, makeAdrs(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs), '0);
    usiCmd = usiBusPkg::usiIdle;
    // First result not before cycle 3
    checkValue("csrReadback", 32'd0, 32'(usiRdVd));
    for (i = 0; i < 3; i++)
    begin
      @(posedge iSCLK);
      #drvDly;
      checkValue("csrReadback", 32'd1, 32'(usiRdVd));
      checkValue("csrReadback", expected[i], usiRd);
    end
    // Unmapped block 2
    busRead(3'd2, 8'h00, rd);
    checkValue("csrReadback", 32'd0, rd);
    // Read in the cycle right after the write
    // Bit 0 always flips so the new value differs from the old one
    newVal = outVal ^ ($random(seed) | 32'd1);
    driveCmd(usiBusPkg::usiWrite, makeAdrs(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs),
             newVal);
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs, rd);
    checkValue("csrReadback", newVal & gpioMask, rd);
    reportTest("csrReadback");
  endtask

  task automatic gpioPins();
    logic [31:0] dirVal;
    logic [31:0] outVal;
    logic [31:0] inVal;
    logic [31:0] rd;
    startTest();
    dirVal = $random(seed);
    outVal = $random(seed);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioAltOfs, 32'd0);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioDirOfs, dirVal);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioOutOfs, outVal);
    checkValue("gpioPins", dirVal & gpioMask, 32'(gpioOe));
    // Only the driven pins matter
    checkValue("gpioPins", outVal & dirVal & gpioMask, 32'(gpioOut & dirVal[gpioWidth-1:0]));
    inVal = $random(seed);
    gpioIn = inVal[gpioWidth-1:0];
    // Longer than the two stage synchronizer
    repeat (3) @(posedge iSCLK);
    #drvDly;
    busRead(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioInOfs, rd);
    checkValue("gpioPins", inVal & gpioMask, rd);
    reportTest("gpioPins");
  endtask

  task automatic timerPulses();
    logic [31:0] reloadVal;
    logic [31:0] rd;
    int i;
    startTest();
    // Reload from 2 to 9 keeps tick one cycle wide
    reloadVal = 32'd2 + ($unsigned($random(seed)) % 32'd8);
    busWrite(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerReloadOfs, reloadVal);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioAltOfs, 32'b010);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioDirOfs, 32'b010);
    busWrite(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerCtrlOfs, 32'd1);
    recordEvents("timerPulses", 1, 1'b0, 3);
    for (i = 1; i < eventCycle.size(); i++)
      checkValue("timerPulses", reloadVal + 32'd1, 32'(eventCycle[i] - eventCycle[i-1]));
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerStatusOfs, rd);
    checkValue("timerPulses", 32'd1, rd);
    // Stop first so no new expiry sets the flag again
    busWrite(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerCtrlOfs, 32'd0);
    busWrite(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerStatusOfs, 32'd1);
    busRead(usiBusPkg::sysTimerAdrsMap, blockCsrPkg::timerStatusOfs, rd);
    checkValue("timerPulses", 32'd0, rd);
    reportTest("timerPulses");
  endtask

  task automatic heartbeatBlink();
    int i;
    startTest();
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioAltOfs, 32'b001);
    busWrite(usiBusPkg::gpioAdrsMap, blockCsrPkg::gpioDirOfs, 32'b001);
    recordEvents("heartbeatBlink", 0, 1'b1, 3);
    for (i = 1; i < eventCycle.size(); i++)
      checkValue("heartbeatBlink", 32'(blinkCntMax + 1), 32'(eventCycle[i] - eventCycle[i-1]));
    reportTest("heartbeatBlink");
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial
  begin
    seed = 32'h1c7b_5749;
    errorCount = 0;
    testCount = 0;
    testErrStart = 0;
    qnARST = 1'b0;
    usiCmd = usiBusPkg::usiIdle;
    usiAdrs = '0;
    usiWd = '0;
    gpioIn = '0;
    repeat (resetCycles) @(posedge iSCLK);
    #drvDly;
    qnARST = 1'b1;
    resetDefaults();
    csrReadback();
    gpioPins();
    timerPulses();
    heartbeatBlink();
    $display("Summary: %0d errors in %0d tests", errorCount, testCount);
    if (errorCount == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    #(watchdogNs);
    $display("Timeout after %0d ns, run did not complete", watchdogNs);
    $display("test failed");
    $finish;
  end

endmodule

// File: usiPeripheralTop.f
src/usiBusPkg.sv
src/blockCsrPkg.sv
src/gpioPin.sv
src/gpioCsr.sv
src/sysTimer.sv
src/heartbeatLed.sv
src/usiBusFabric.sv
src/usiPeripheralTop.sv
verification/usiBus_asserts.sv
verification/usiPeripheralTb.sv

// File: Makefile
# Verilator build and run of the USI peripheral testbench
# Any variable can be overridden, e.g. make run PASS_MSG="test passed"

VERILATOR ?= verilator
TOP       ?= usiPeripheralTb
FILELIST  ?= usiPeripheralTop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
